// ==== rtl/mmioPkg.sv ====
package mmioPkg;

	// Bus and storage sizes
	localparam int dataWidth = 32;
	localparam int addrWidth = 32;
	localparam int gpioWidth = 8;
	localparam int ramWords = 1024;
	localparam int ramIndexWidth = 10;

	// Peripheral page, one byte address per register
	localparam logic [addrWidth-1:0] addrSevenSeg = 32'd255;
	localparam logic [addrWidth-1:0] addrBootAddress = 32'd259;
	localparam logic [addrWidth-1:0] addrMsCounter = 32'd267;
	localparam logic [addrWidth-1:0] addrUsCounter = 32'd271;
	localparam logic [addrWidth-1:0] addrSwapRequest = 32'd275;
	localparam logic [addrWidth-1:0] addrGpioOut = 32'd283;
	localparam logic [addrWidth-1:0] addrGpioIn = 32'd287;

	// First byte of main RAM
	localparam logic [addrWidth-1:0] ramBase = 32'd1024;

	// Where the processor starts after reset
	localparam logic [dataWidth-1:0] bootAddressReset = 32'h3FC;

	// Clock cycles per tick of each time base
	localparam int msPrescale = 8333;
	localparam int usPrescale = 8;
	// Sized for the larger of the two prescalers
	localparam int prescaleWidth = $clog2(msPrescale);

	typedef enum logic [3:0] {
		none,
		sevenSeg,
		bootAddress,
		msCounter,
		usCounter,
		swapRequest,
		gpioOut,
		gpioIn,
		ram
	} regionT;

endpackage

// ==== rtl/addressDecoder.sv ====
`timescale 1ns/1ps

module addressDecoder (
	input logic [mmioPkg::addrWidth-1:0] address,
	input logic writeEnable,
	output mmioPkg::regionT region,
	output logic sevenSegWrite,
	output logic bootWrite,
	output logic swapWrite,
	output logic gpioWrite,
	output logic ramWrite
);

	logic [mmioPkg::addrWidth-1:0] ramOffset;
	logic inRam;

	// RAM window is ramBase up to four bytes per word past it
	always_comb begin
		ramOffset = address - mmioPkg::ramBase;
		inRam = (address >= mmioPkg::ramBase) &&
			(ramOffset[mmioPkg::addrWidth-1:mmioPkg::ramIndexWidth+2] == '0);
	end

	always_comb begin
		if (inRam) begin
			region = mmioPkg::ram;
		end
		else begin
			case (address)
				mmioPkg::addrSevenSeg: region = mmioPkg::sevenSeg;
				mmioPkg::addrBootAddress: region = mmioPkg::bootAddress;
				mmioPkg::addrMsCounter: region = mmioPkg::msCounter;
				mmioPkg::addrUsCounter: region = mmioPkg::usCounter;
				mmioPkg::addrSwapRequest: region = mmioPkg::swapRequest;
				mmioPkg::addrGpioOut: region = mmioPkg::gpioOut;
				mmioPkg::addrGpioIn: region = mmioPkg::gpioIn;
				// Keyboard range and everything else land here
				default: region = mmioPkg::none;
			endcase
		end
	end

	// Only writable targets get a strobe
	assign sevenSegWrite = writeEnable && (region == mmioPkg::sevenSeg);
	assign bootWrite = writeEnable && (region == mmioPkg::bootAddress);
	assign swapWrite = writeEnable && (region == mmioPkg::swapRequest);
	assign gpioWrite = writeEnable && (region == mmioPkg::gpioOut);
	assign ramWrite = writeEnable && (region == mmioPkg::ram);

endmodule

// ==== rtl/controlRegisters.sv ====
`timescale 1ns/1ps

module controlRegisters (
	input logic clk,
	input logic rst,
	input logic [mmioPkg::dataWidth-1:0] writeData,
	input logic sevenSegWrite,
	input logic bootWrite,
	input logic swapWrite,
	input logic gpioWrite,
	input logic frameDone,
	input logic [mmioPkg::gpioWidth-1:0] gpioIn,
	output logic [mmioPkg::dataWidth-1:0] sevenSeg,
	output logic [mmioPkg::dataWidth-1:0] bootAddress,
	output logic swapRequest,
	output logic [mmioPkg::gpioWidth-1:0] gpioOut,
	output logic [mmioPkg::gpioWidth-1:0] gpioInSync,
	output logic displayBuffer
);

	logic swapNow;

	// Swap happens only at the end of a frame with a request pending
	assign swapNow = frameDone && swapRequest;

	// Display word and boot address
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			sevenSeg <= '0;
			bootAddress <= mmioPkg::bootAddressReset;
		end
		else begin
			if (sevenSegWrite)
				sevenSeg <= writeData;
			if (bootWrite)
				bootAddress <= writeData;
		end
	end

	// Buffer swap request and the displayed buffer
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			swapRequest <= 1'b0;
			displayBuffer <= 1'b0;
		end
		else begin
			// A fresh write beats the clear at frame end
			if (swapWrite)
				swapRequest <= writeData[0];
			else if (swapNow)
				swapRequest <= 1'b0;
			if (swapNow)
				displayBuffer <= ~displayBuffer;
		end
	end

	// GPIO out keeps the low bits, GPIO in is sampled every cycle
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			gpioOut <= '0;
			gpioInSync <= '0;
		end
		else begin
			if (gpioWrite)
				gpioOut <= writeData[mmioPkg::gpioWidth-1:0];
			gpioInSync <= gpioIn;
		end
	end

	// The visible buffer must never flip mid-frame
	displayBufferOnFrame: assert property (
		@(posedge clk) disable iff (rst == 1'b0)
		$changed(displayBuffer) |-> $past(frameDone)
	);

endmodule

// ==== rtl/timeCounters.sv ====
`timescale 1ns/1ps

module timeCounters (
	input logic clk,
	input logic rst,
	output logic [mmioPkg::dataWidth-1:0] msCount,
	output logic [mmioPkg::dataWidth-1:0] usCount
);

	// Index 0 is the millisecond base, index 1 the microsecond base
	for (genvar i = 0; i < 2; i++) begin : genTick
		logic [mmioPkg::prescaleWidth-1:0] preCount;
		logic [mmioPkg::dataWidth-1:0] count;
		logic wrap;

		assign wrap = (preCount == mmioPkg::prescaleWidth'(
			((i == 0) ? mmioPkg::msPrescale : mmioPkg::usPrescale) - 1));

		always_ff @(posedge clk or negedge rst) begin
			if (rst == 1'b0) begin
				preCount <= '0;
				count <= '0;
			end
			else if (wrap) begin
				// End of a full prescale period
				preCount <= '0;
				count <= count + 1'b1;
			end
			else begin
				preCount <= preCount + 1'b1;
			end
		end

		if (i == 0) begin : genMs
			assign msCount = count;
		end
		else begin : genUs
			assign usCount = count;
		end
	end

endmodule

// ==== rtl/wordRam.sv ====
`timescale 1ns/1ps

module wordRam #(
	parameter int words = mmioPkg::ramWords
) (
	input logic clk,
	input logic [mmioPkg::addrWidth-1:0] address,
	input logic [mmioPkg::dataWidth-1:0] writeData,
	input logic ramWrite,
	output logic [mmioPkg::dataWidth-1:0] ramData
);

	logic [mmioPkg::dataWidth-1:0] mem [words];
	logic [mmioPkg::addrWidth-1:0] offset;
	logic [$clog2(words)-1:0] index;

	// Byte offset into RAM, then drop the byte lane bits
	assign offset = address - mmioPkg::ramBase;
	assign index = offset[$clog2(words)+1:2];

	// Read every cycle; a write in the same cycle is passed straight through
	always_ff @(posedge clk) begin
		if (ramWrite) begin
			mem[index] <= writeData;
			ramData <= writeData;
		end
		else begin
			ramData <= mem[index];
		end
	end

endmodule

// ==== rtl/readMux.sv ====
`timescale 1ns/1ps

module readMux (
	input logic clk,
	input logic rst,
	input mmioPkg::regionT region,
	input logic readEnable,
	input logic [mmioPkg::dataWidth-1:0] sevenSeg,
	input logic [mmioPkg::dataWidth-1:0] bootAddress,
	input logic swapRequest,
	input logic [mmioPkg::gpioWidth-1:0] gpioOut,
	input logic [mmioPkg::gpioWidth-1:0] gpioInSync,
	input logic [mmioPkg::dataWidth-1:0] msCount,
	input logic [mmioPkg::dataWidth-1:0] usCount,
	input logic [mmioPkg::dataWidth-1:0] ramData,
	output logic [mmioPkg::dataWidth-1:0] readData
);

	mmioPkg::regionT regionQ;
	logic readQ;

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			regionQ <= mmioPkg::none;
			readQ <= 1'b0;
		end
		else begin
			regionQ <= region;
			readQ <= readEnable;
		end
	end

	// Narrow sources are zero-extended to a full word
	always_comb begin
		readData = '0;
		if (readQ) begin
			case (regionQ)
				mmioPkg::sevenSeg: readData = sevenSeg;
				mmioPkg::bootAddress: readData = bootAddress;
				mmioPkg::msCounter: readData = msCount;
				mmioPkg::usCounter: readData = usCount;
				mmioPkg::swapRequest: readData = {{(mmioPkg::dataWidth-1){1'b0}}, swapRequest};
				mmioPkg::gpioOut: readData = {{(mmioPkg::dataWidth-mmioPkg::gpioWidth){1'b0}}, gpioOut};
				mmioPkg::gpioIn: readData = {{(mmioPkg::dataWidth-mmioPkg::gpioWidth){1'b0}}, gpioInSync};
				mmioPkg::ram: readData = ramData;
				default: readData = '0;
			endcase
		end
	end

	// Bus stays quiet in any cycle that does not follow a read
	idleReadZero: assert property (
		@(posedge clk) disable iff (rst == 1'b0)
		!$past(readEnable) |-> (readData == '0)
	);

endmodule

// ==== rtl/mmioSystem.sv ====
`timescale 1ns/1ps

module mmioSystem (
	input logic clk,
	input logic rst,
	input logic [mmioPkg::addrWidth-1:0] address,
	input logic [mmioPkg::dataWidth-1:0] writeData,
	input logic writeEnable,
	input logic readEnable,
	input logic frameDone,
	input logic [mmioPkg::gpioWidth-1:0] gpioIn,
	output logic [mmioPkg::dataWidth-1:0] readData,
	output logic [mmioPkg::dataWidth-1:0] sevenSeg,
	output logic [mmioPkg::dataWidth-1:0] bootAddress,
	output logic [mmioPkg::gpioWidth-1:0] gpioOut,
	output logic displayBuffer
);

	mmioPkg::regionT region;
	logic sevenSegWrite;
	logic bootWrite;
	logic swapWrite;
	logic gpioWrite;
	logic ramWrite;
	logic swapRequest;
	logic [mmioPkg::gpioWidth-1:0] gpioInSync;
	logic [mmioPkg::dataWidth-1:0] msCount;
	logic [mmioPkg::dataWidth-1:0] usCount;
	logic [mmioPkg::dataWidth-1:0] ramData;

	addressDecoder decoder (
		.address(address),
		.writeEnable(writeEnable),
		.region(region),
		.sevenSegWrite(sevenSegWrite),
		.bootWrite(bootWrite),
		.swapWrite(swapWrite),
		.gpioWrite(gpioWrite),
		.ramWrite(ramWrite)
	);

	controlRegisters regs (
		.clk(clk),
		.rst(rst),
		.writeData(writeData),
		.sevenSegWrite(sevenSegWrite),
		.bootWrite(bootWrite),
		.swapWrite(swapWrite),
		.gpioWrite(gpioWrite),
		.frameDone(frameDone),
		.gpioIn(gpioIn),
		.sevenSeg(sevenSeg),
		.bootAddress(bootAddress),
		.swapRequest(swapRequest),
		.gpioOut(gpioOut),
		.gpioInSync(gpioInSync),
		.displayBuffer(displayBuffer)
	);

	timeCounters counters (
		.clk(clk),
		.rst(rst),
		.msCount(msCount),
		.usCount(usCount)
	);

	wordRam mainRam (
		.clk(clk),
		.address(address),
		.writeData(writeData),
		.ramWrite(ramWrite),
		.ramData(ramData)
	);

	readMux readBack (
		.clk(clk),
		.rst(rst),
		.region(region),
		.readEnable(readEnable),
		.sevenSeg(sevenSeg),
		.bootAddress(bootAddress),
		.swapRequest(swapRequest),
		.gpioOut(gpioOut),
		.gpioInSync(gpioInSync),
		.msCount(msCount),
		.usCount(usCount),
		.ramData(ramData),
		.readData(readData)
	);

endmodule

// ==== bench/mmioSystemTb.sv ====
`timescale 1ns/1ps

module mmioSystemTb;

	// Two millisecond periods for the counter test plus room for the rest
	localparam int timeoutCycles = 40000;

	logic clk;
	logic rst;
	logic [mmioPkg::addrWidth-1:0] address;
	logic [mmioPkg::dataWidth-1:0] writeData;
	logic writeEnable;
	logic readEnable;
	logic frameDone;
	logic [mmioPkg::gpioWidth-1:0] gpioIn;
	logic [mmioPkg::dataWidth-1:0] readData;
	logic [mmioPkg::dataWidth-1:0] sevenSeg;
	logic [mmioPkg::dataWidth-1:0] bootAddress;
	logic [mmioPkg::gpioWidth-1:0] gpioOut;
	logic displayBuffer;

	// Expected state of the registers and RAM
	logic [31:0] modelSevenSeg;
	logic [31:0] modelBoot;
	logic [7:0] modelGpioOut;
	logic [7:0] modelGpioIn;
	logic modelSwap;
	logic modelDisplay;
	logic [31:0] modelRam [mmioPkg::ramWords];
	int cycles;

	mmioSystem dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic inRam(input logic [31:0] addr);
		return addr >= mmioPkg::ramBase &&
			(addr - mmioPkg::ramBase) < 32'(4 * mmioPkg::ramWords);
	endfunction

	function automatic logic isCounter(input logic [31:0] addr);
		return addr == mmioPkg::addrMsCounter || addr == mmioPkg::addrUsCounter;
	endfunction

	// Word the bus should return for a read of addr
	function automatic logic [31:0] expectedRead(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - mmioPkg::ramBase;
		if (inRam(addr))
			return modelRam[offset[mmioPkg::ramIndexWidth+1:2]];
		case (addr)
			mmioPkg::addrSevenSeg: return modelSevenSeg;
			mmioPkg::addrBootAddress: return modelBoot;
			mmioPkg::addrSwapRequest: return 32'(modelSwap);
			mmioPkg::addrGpioOut: return 32'(modelGpioOut);
			mmioPkg::addrGpioIn: return 32'(modelGpioIn);
			default: return '0;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name,
				actual, expected);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic driveCycle(input logic we, input logic re, input logic [31:0] addr,
		input logic [31:0] data, input logic frame);
		@(posedge clk);
		#1;
		writeEnable = we;
		readEnable = re;
		address = addr;
		writeData = data;
		frameDone = frame;
	endtask

	task automatic idle(input int n);
		repeat (n) driveCycle(1'b0, 1'b0, 32'd0, 32'd0, 1'b0);
	endtask

	task automatic checkOutputs();
		checkValue("sevenSeg", sevenSeg, modelSevenSeg);
		checkValue("bootAddress", bootAddress, modelBoot);
		checkValue("gpioOut", 32'(gpioOut), 32'(modelGpioOut));
		checkValue("displayBuffer", 32'(displayBuffer), 32'(modelDisplay));
	endtask

	task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] offset;
		offset = addr - mmioPkg::ramBase;
		driveCycle(1'b1, 1'b0, addr, data, 1'b0);
		if (inRam(addr))
			modelRam[offset[mmioPkg::ramIndexWidth+1:2]] = data;
		case (addr)
			mmioPkg::addrSevenSeg: modelSevenSeg = data;
			mmioPkg::addrBootAddress: modelBoot = data;
			mmioPkg::addrSwapRequest: modelSwap = data[0];
			mmioPkg::addrGpioOut: modelGpioOut = data[7:0];
			default: ;
		endcase
		// Outputs must have moved one cycle after the write
		idle(1);
		checkOutputs();
	endtask

	task automatic readWord(input logic [31:0] addr);
		driveCycle(1'b0, 1'b1, addr, 32'd0, 1'b0);
	endtask

	task automatic pulseFrame();
		driveCycle(1'b0, 1'b0, 32'd0, 32'd0, 1'b1);
		if (modelSwap) begin
			modelSwap = 1'b0;
			modelDisplay = ~modelDisplay;
		end
		idle(1);
		checkOutputs();
	endtask

	task automatic readCounter(input logic [31:0] addr, output logic [31:0] value);
		readWord(addr);
		idle(1);
		#20;
		value = readData;
	endtask

	// Two samples gap cycles apart must differ by gap / prescale, give or take one
	task automatic checkCounter(input string name, input logic [31:0] addr,
		input int prescale, input int gap);
		logic [31:0] first;
		logic [31:0] second;
		logic [31:0] diff;
		int steps;
		readCounter(addr, first);
		// A write between the samples must not move the count
		writeWord(addr, $urandom());
		idle(gap - 4);
		readCounter(addr, second);
		diff = second - first;
		steps = gap / prescale;
		if (diff + 1 < steps || diff > steps + 1) begin
			$display("%s advanced by %0d over %0d cycles, about %0d expected",
				name, diff, gap, steps);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// Every cycle readData must match the read sampled at the edge before, or be zero
	initial begin
		logic dueRead;
		logic [31:0] dueAddr;
		logic [31:0] dueExpected;
		forever begin
			@(posedge clk);
			dueRead = rst && readEnable;
			dueAddr = address;
			dueExpected = dueRead ? expectedRead(address) : 32'd0;
			@(negedge clk);
			if (rst && !(dueRead && isCounter(dueAddr)))
				checkValue("readData", readData, dueExpected);
		end
	end

	initial begin
		cycles = 0;
		while (cycles < timeoutCycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests never finished", cycles);
		$display("Something failed");
		$fatal(1);
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] unmapped [7];
		int ramIndex [$];
		rst = 1'b0;
		address = '0;
		writeData = '0;
		writeEnable = 1'b0;
		readEnable = 1'b0;
		frameDone = 1'b0;
		gpioIn = '0;
		modelSevenSeg = '0;
		modelBoot = mmioPkg::bootAddressReset;
		modelGpioOut = '0;
		modelGpioIn = '0;
		modelSwap = 1'b0;
		modelDisplay = 1'b0;
		void'($urandom(32'h300e));
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;

		checkOutputs();
		readWord(mmioPkg::addrBootAddress);
		idle(3);

		for (int i = 0; i < 6; i++) begin
			writeWord(mmioPkg::addrSevenSeg, $urandom());
			writeWord(mmioPkg::addrBootAddress, $urandom());
			writeWord(mmioPkg::addrGpioOut, $urandom());
			readWord(mmioPkg::addrSevenSeg);
			readWord(mmioPkg::addrBootAddress);
			readWord(mmioPkg::addrGpioOut);
		end

		for (int i = 0; i < 24; i++) begin
			ramIndex.push_back(int'($urandom() % mmioPkg::ramWords));
			writeWord(mmioPkg::ramBase + 32'(4 * ramIndex[i]), $urandom());
		end
		foreach (ramIndex[i])
			readWord(mmioPkg::ramBase + 32'(4 * ramIndex[i]));
		unmapped = '{32'd0, 32'd263, 32'd279, 32'd291, 32'd1023, 32'd5120, 32'hFFFFFFFC};
		foreach (unmapped[i])
			readWord(unmapped[i]);
		writeWord(mmioPkg::addrGpioIn, $urandom());
		readWord(mmioPkg::addrGpioIn);

		// No request pending, so the frame end must not swap
		pulseFrame();
		for (int i = 0; i < 3; i++) begin
			writeWord(mmioPkg::addrSwapRequest, 32'd1);
			readWord(mmioPkg::addrSwapRequest);
			pulseFrame();
			readWord(mmioPkg::addrSwapRequest);
		end

		for (int i = 0; i < 4; i++) begin
			idle(1);
			rnd = $urandom();
			gpioIn = rnd[7:0];
			modelGpioIn = rnd[7:0];
			idle(1);
			readWord(mmioPkg::addrGpioIn);
		end

		checkCounter("usCount", mmioPkg::addrUsCounter, mmioPkg::usPrescale, 100);
		checkCounter("msCount", mmioPkg::addrMsCounter, mmioPkg::msPrescale,
			2 * mmioPkg::msPrescale);
		idle(2);
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== mmioSystem.f ====
rtl/mmioPkg.sv
rtl/addressDecoder.sv
rtl/controlRegisters.sv
rtl/timeCounters.sv
rtl/wordRam.sv
rtl/readMux.sv
rtl/mmioSystem.sv
bench/mmioSystemTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST ?= mmioSystem.f
TOP ?= mmioSystemTb
LINT_TOP ?= mmioSystem
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= Everything OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
